//--- all.f
logic/exec_pkg.sv
logic/exec_operand_sel.sv
logic/exec_alu.sv
logic/exec_branch.sv
logic/exec_mem_reg.sv
logic/exec_stage.sv
verif/exec_stage_tb.sv

//--- logic/exec_alu.sv
/*
 * Execute-stage ALU.
 * Produces alu_out from the selected operands and the csr write value
 * from the forwarded rs1, the csr operand and the pc. Combinational;
 * clk and rst only clock the result checks.
 */

`timescale 1ns/1ns

module exec_alu (
    input  logic                      clk,
    input  logic                      rst,
    input  exec_pkg::ex_ctrl_t        ctrl,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  exec_pkg::ex_opnd_t        opnd,
    output exec_pkg::alu_res_t        res
);

    import exec_pkg::*;

    logic [4:0]    shamt;
    logic          lt_signed;
    logic          lt_unsigned;
    logic [XLEN:0] diff_s;
    logic [XLEN:0] diff_u;

    assign shamt       = opnd.b[4:0];
    assign lt_signed   = $signed(opnd.a) < $signed(opnd.b);
    assign lt_unsigned = opnd.a < opnd.b;

    // ==================================================
    // arithmetic and logic
    // ==================================================
    always_comb begin
        case (ctrl.alu_op)
            alu_add:    res.alu_out = opnd.a + opnd.b;
            alu_sub:    res.alu_out = opnd.a - opnd.b;
            alu_slt:    res.alu_out = {{(XLEN-1){1'b0}}, lt_signed};
            alu_sltu:   res.alu_out = {{(XLEN-1){1'b0}}, lt_unsigned};
            alu_or:     res.alu_out = opnd.a | opnd.b;
            alu_and:    res.alu_out = opnd.a & opnd.b;
            alu_xor:    res.alu_out = opnd.a ^ opnd.b;
            alu_sll:    res.alu_out = opnd.a << shamt;
            alu_srl:    res.alu_out = opnd.a >> shamt;
            alu_sra:    res.alu_out = $unsigned($signed(opnd.a) >>> shamt);
            alu_pass_b: res.alu_out = opnd.b;
            default:    res.alu_out = '0;
        endcase
    end

    // ==================================================
    // csr new value
    // ==================================================
    always_comb begin
        case (ctrl.csr_op)
            csr_op_rw:    res.csr_out = opnd.rs1;
            csr_op_rs:    res.csr_out = opnd.csr | opnd.rs1;
            // ecall saves the trapping pc into mepc
            csr_op_ecall: res.csr_out = pc;
            default:      res.csr_out = '0;
        endcase
    end

    // ==================================================
    // checks
    // ==================================================
    // wide subtracts, the top bit is the borrow
    assign diff_s = {opnd.a[XLEN-1], opnd.a} - {opnd.b[XLEN-1], opnd.b};
    assign diff_u = {1'b0, opnd.a} - {1'b0, opnd.b};

    default clocking cb @(posedge clk);
    endclocking

    default disable iff (rst);

    // compares must return a clean 0 or 1 matching the borrow
    a_slt_borrow: assert property (
        (ctrl.alu_op == alu_slt) |-> (res.alu_out == XLEN'(diff_s[XLEN]))
    );

    a_sltu_borrow: assert property (
        (ctrl.alu_op == alu_sltu) |-> (res.alu_out == XLEN'(diff_u[XLEN]))
    );

endmodule

//--- logic/exec_branch.sv
/*
 * Branch unit of the execute stage.
 * Evaluates the branch condition on the forwarded operands and forms the
 * jump or branch target. Has its own comparator so it runs alongside the
 * ALU instead of after it. Combinational.
 */

`timescale 1ns/1ns

module exec_branch (
    input  exec_pkg::br_kind_e        br_kind,
    input  logic [exec_pkg::XLEN-1:0] pc,
    input  logic [exec_pkg::XLEN-1:0] imm,
    input  exec_pkg::ex_opnd_t        opnd,
    output exec_pkg::br_res_t         res
);

    import exec_pkg::*;

    logic            eq;
    logic            lt;
    logic [XLEN-1:0] pc_imm;
    logic [XLEN-1:0] rs1_imm;
    logic [XLEN-1:0] csr_imm;

    // comparator on rs1 vs rs2, signed for bge and blt
    assign eq = opnd.rs1 == opnd.rs2;
    assign lt = $signed(opnd.rs1) < $signed(opnd.rs2);

    assign pc_imm  = pc + imm;
    assign rs1_imm = opnd.rs1 + imm;
    assign csr_imm = opnd.csr + imm;

    // ==================================================
    // condition and target
    // ==================================================
    always_comb begin
        res.target = pc_imm;
        case (br_kind)
            br_none: begin
                res.taken = 1'b0;
            end
            br_jmp_pc: begin
                res.taken = 1'b1;
            end
            br_jmp_rs1: begin
                // jalr drops the low bit
                res.taken  = 1'b1;
                res.target = {rs1_imm[XLEN-1:1], 1'b0};
            end
            br_jmp_csr: begin
                res.taken  = 1'b1;
                res.target = csr_imm;
            end
            br_beq:  res.taken = eq;
            br_bne:  res.taken = ~eq;
            br_bge:  res.taken = ~lt;
            br_blt:  res.taken = lt;
            default: res.taken = 1'b0;
        endcase
    end

endmodule

//--- logic/exec_mem_reg.sv
/*
 * EX/MEM pipeline register.
 * Merges the ALU and branch results with the pass-through fields of the
 * instruction and captures them on each rising clock edge. A captured
 * taken redirect raises pc_src and both flushes for one cycle and marks
 * the next instruction into execute as a wrong-path shadow.
 */

`timescale 1ns/1ns

module exec_mem_reg (
    input  logic                      clk,
    input  logic                      rst,
    input  exec_pkg::ex_in_t          in,
    input  exec_pkg::alu_res_t        alu,
    input  exec_pkg::br_res_t         br,
    output exec_pkg::ex_mem_t         ex_mem,
    output logic                      pc_src,
    output logic                      flush_if,
    output logic                      flush_id,
    output logic [exec_pkg::XLEN-1:0] branch_target
);

    import exec_pkg::*;

    ex_mem_t ex_mem_d;
    logic    shadow_q;
    logic    kill;
    logic    redirect;

    // shadow slot or bubble
    assign kill     = shadow_q | ~in.op_valid;
    assign redirect = br.taken & ~kill;

    // ==================================================
    // next EX/MEM word
    // ==================================================
    always_comb begin
        ex_mem_d.op_valid   = ~kill;
        ex_mem_d.alu_out    = alu.alu_out;
        ex_mem_d.csr_out    = alu.csr_out;
        ex_mem_d.rd         = in.rd;
        ex_mem_d.rs1        = in.rs1;
        ex_mem_d.rs2        = in.rs2;
        ex_mem_d.csr_rd     = in.csr_rd;
        ex_mem_d.csr_rs     = in.csr_rs;
        ex_mem_d.write_gpr  = in.ctrl.write_gpr & ~kill;
        ex_mem_d.write_csr  = in.ctrl.write_csr & ~kill;
        ex_mem_d.mem_to_reg = in.ctrl.mem_to_reg;
        ex_mem_d.write_mem  = in.ctrl.write_mem & ~kill;
        ex_mem_d.mem_size   = in.ctrl.mem_size;
        ex_mem_d.halt       = in.ctrl.halt & ~kill;
    end

    // payload loads every cycle, control fields are cleared on reset
    always_ff @(posedge clk) begin
        ex_mem        <= ex_mem_d;
        branch_target <= br.target;
        if (rst) begin
            ex_mem.op_valid  <= 1'b0;
            ex_mem.write_gpr <= 1'b0;
            ex_mem.write_csr <= 1'b0;
            ex_mem.write_mem <= 1'b0;
            ex_mem.halt      <= 1'b0;
            pc_src           <= 1'b0;
            flush_if         <= 1'b0;
            flush_id         <= 1'b0;
            shadow_q         <= 1'b0;
        end else begin
            pc_src   <= redirect;
            flush_if <= redirect;
            flush_id <= redirect;
            shadow_q <= redirect;
        end
    end

    // ==================================================
    // checks
    // ==================================================
    default clocking cb @(posedge clk);
    endclocking

    default disable iff (rst);

    // the shadow kill must stop back-to-back redirects
    a_pc_src_single: assert property (pc_src |=> !pc_src);

    // slot after a redirect is stored as a dead shadow
    a_shadow_killed: assert property (pc_src |=> !ex_mem.op_valid);

endmodule

//--- logic/exec_operand_sel.sv
/*
 * Operand selection for the execute stage.
 * Applies the forwarding overrides to rs1, rs2 and the csr value, then
 * picks the two ALU operands from the control word. Purely combinational,
 * the results feed both the ALU and the branch unit.
 */

`timescale 1ns/1ns

module exec_operand_sel (
    input  exec_pkg::ex_in_t   in,
    input  exec_pkg::fwd_t     fwd,
    output exec_pkg::ex_opnd_t opnd
);

    import exec_pkg::*;

    localparam logic [XLEN-1:0] inst_bytes = XLEN'(4);

    // ==================================================
    // forwarding override
    // ==================================================
    always_comb begin
        if (fwd.rs1_hz) begin
            opnd.rs1 = fwd.rs1_data;
        end else begin
            opnd.rs1 = in.rs1_data;
        end

        if (fwd.rs2_hz) begin
            opnd.rs2 = fwd.rs2_data;
        end else begin
            opnd.rs2 = in.rs2_data;
        end

        if (fwd.csr_hz) begin
            opnd.csr = fwd.csr_data;
        end else begin
            opnd.csr = in.csr_data;
        end

        // ==================================================
        // alu source muxes
        // ==================================================
        case (in.ctrl.src_a)
            src_a_rs1: opnd.a = opnd.rs1;
            src_a_pc:  opnd.a = in.pc;
            default:   opnd.a = opnd.rs1;
        endcase

        case (in.ctrl.src_b)
            src_b_rs2:  opnd.b = opnd.rs2;
            src_b_imm:  opnd.b = in.imm;
            // link address for jal and jalr
            src_b_four: opnd.b = inst_bytes;
            src_b_csr:  opnd.b = opnd.csr;
            default:    opnd.b = opnd.rs2;
        endcase
    end

endmodule

//--- logic/exec_pkg.sv
/*
 * Shared types for the RV32 execute stage.
 * Holds the data widths, the decoded control encodings and the packed
 * bundles passed between the execute blocks. RTL and testbench import
 * this package; it has to be compiled before every other source.
 */

package exec_pkg;

    localparam int XLEN  = 32;
    localparam int REG_W = 5;
    localparam int CSR_W = 2;

    // ==================================================
    // control encodings
    // ==================================================
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_slt    = 4'd2,
        alu_sltu   = 4'd3,
        alu_or     = 4'd4,
        alu_and    = 4'd5,
        alu_xor    = 4'd6,
        alu_sll    = 4'd7,
        alu_srl    = 4'd8,
        alu_sra    = 4'd9,
        // lui goes through here
        alu_pass_b = 4'd10
    } alu_op_e;

    typedef enum logic {
        src_a_rs1 = 1'b0,
        src_a_pc  = 1'b1
    } src_a_e;

    typedef enum logic [1:0] {
        src_b_rs2  = 2'd0,
        src_b_imm  = 2'd1,
        src_b_four = 2'd2,
        src_b_csr  = 2'd3
    } src_b_e;

    typedef enum logic [2:0] {
        br_none    = 3'd0,
        br_jmp_pc  = 3'd1,
        br_jmp_rs1 = 3'd2,
        // mret returns through the csr value
        br_jmp_csr = 3'd3,
        br_beq     = 3'd4,
        br_bne     = 3'd5,
        br_bge     = 3'd6,
        br_blt     = 3'd7
    } br_kind_e;

    typedef enum logic [1:0] {
        csr_op_none  = 2'd0,
        csr_op_rw    = 2'd1,
        csr_op_rs    = 2'd2,
        csr_op_ecall = 2'd3
    } csr_op_e;

    typedef enum logic [2:0] {
        mem_byte   = 3'd0,
        mem_half   = 3'd1,
        mem_word   = 3'd2,
        mem_byte_u = 3'd3,
        mem_half_u = 3'd4
    } mem_size_e;

    // ==================================================
    // bundles
    // ==================================================
    typedef struct packed {
        alu_op_e   alu_op;
        src_a_e    src_a;
        src_b_e    src_b;
        br_kind_e  br_kind;
        csr_op_e   csr_op;
        logic      write_gpr;
        logic      write_csr;
        logic      mem_to_reg;
        logic      write_mem;
        mem_size_e mem_size;
        logic      halt;
    } ex_ctrl_t;

    typedef struct packed {
        logic             op_valid;
        ex_ctrl_t         ctrl;
        logic [XLEN-1:0]  pc;
        logic [XLEN-1:0]  imm;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [CSR_W-1:0] csr_rd;
        logic [CSR_W-1:0] csr_rs;
        logic [XLEN-1:0]  rs1_data;
        logic [XLEN-1:0]  rs2_data;
        logic [XLEN-1:0]  csr_data;
    } ex_in_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1_data;
        logic [XLEN-1:0] rs2_data;
        logic [XLEN-1:0] csr_data;
        logic            rs1_hz;
        logic            rs2_hz;
        logic            csr_hz;
    } fwd_t;

    typedef struct packed {
        logic [XLEN-1:0] rs1;
        logic [XLEN-1:0] rs2;
        logic [XLEN-1:0] csr;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
    } ex_opnd_t;

    typedef struct packed {
        logic [XLEN-1:0] alu_out;
        logic [XLEN-1:0] csr_out;
    } alu_res_t;

    typedef struct packed {
        logic            taken;
        logic [XLEN-1:0] target;
    } br_res_t;

    typedef struct packed {
        logic             op_valid;
        logic [XLEN-1:0]  alu_out;
        logic [XLEN-1:0]  csr_out;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [CSR_W-1:0] csr_rd;
        logic [CSR_W-1:0] csr_rs;
        logic             write_gpr;
        logic             write_csr;
        logic             mem_to_reg;
        logic             write_mem;
        mem_size_e        mem_size;
        logic             halt;
    } ex_mem_t;

endpackage

//--- logic/exec_stage.sv
/*
 * Execute stage top level of the five-stage RV32 core.
 * Takes the decoded instruction and the forwarding values, runs the
 * arithmetic and control-flow paths side by side and registers the
 * EX/MEM word together with the fetch redirect and pipeline flushes.
 * All outputs appear one cycle after their inputs are sampled.
 */

`timescale 1ns/1ns

module exec_stage (
    input  logic                      clk,
    input  logic                      rst,
    input  exec_pkg::ex_in_t          in,
    input  exec_pkg::fwd_t            fwd,
    output exec_pkg::ex_mem_t         ex_mem,
    output logic                      pc_src,
    output logic                      flush_if,
    output logic                      flush_id,
    output logic [exec_pkg::XLEN-1:0] branch_target
);

    import exec_pkg::*;

    ex_opnd_t opnd;
    alu_res_t alu_res;
    br_res_t  br_res;

    // ==================================================
    // operand path
    // ==================================================
    exec_operand_sel exec_operand_sel_inst (
        .in   (in),
        .fwd  (fwd),
        .opnd (opnd)
    );

    // ==================================================
    // arithmetic and control-flow paths
    // ==================================================
    exec_alu exec_alu_inst (
        .clk  (clk),
        .rst  (rst),
        .ctrl (in.ctrl),
        .pc   (in.pc),
        .opnd (opnd),
        .res  (alu_res)
    );

    exec_branch exec_branch_inst (
        .br_kind (in.ctrl.br_kind),
        .pc      (in.pc),
        .imm     (in.imm),
        .opnd    (opnd),
        .res     (br_res)
    );

    // ==================================================
    // EX/MEM register
    // ==================================================
    exec_mem_reg exec_mem_reg_inst (
        .clk           (clk),
        .rst           (rst),
        .in            (in),
        .alu           (alu_res),
        .br            (br_res),
        .ex_mem        (ex_mem),
        .pc_src        (pc_src),
        .flush_if      (flush_if),
        .flush_id      (flush_id),
        .branch_target (branch_target)
    );

endmodule

//--- run_sim.sh
#!/bin/sh
# Build the execute-stage testbench with Verilator and run it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module exec_stage_tb -f all.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vexec_stage_tb)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "SIMULATION PASSED"; then
    exit 0
fi
echo "pass message not found in simulation output"
exit 1

//--- verif/exec_stage_tb.sv
/*
 * Testbench for the execute stage.
 * Applies a hand-checked table of instructions one per cycle and then
 * 64 random ALU operations against a small reference model. Each result
 * is checked on the falling edge one cycle after the inputs were driven.
 */

`timescale 1ns/1ns

module exec_stage_tb;

    import exec_pkg::*;

    localparam int MAX_ROWS = 48;
    localparam int RAND_OPS = 64;

    logic              clk;
    logic              rst;
    ex_in_t            in_drv;
    fwd_t              fwd_drv;
    ex_mem_t           ex_mem;
    logic              pc_src;
    logic              flush_if;
    logic              flush_id;
    logic [XLEN-1:0]   branch_target;

    ex_in_t            tbl_in [MAX_ROWS];
    fwd_t              tbl_fwd [MAX_ROWS];
    logic [XLEN-1:0]   exp_alu [MAX_ROWS];
    logic [XLEN-1:0]   exp_csr [MAX_ROWS];
    logic              exp_taken [MAX_ROWS];
    logic [XLEN-1:0]   exp_target [MAX_ROWS];
    int                n_rows = 0;

    int                pass_count = 0;
    int                fail_count = 0;
    int                cycles = 0;
    int                cycle_limit = 1000;
    logic              shadow_exp = 1'b0;
    integer            seed;

    exec_stage exec_stage_inst (
        .clk           (clk),
        .rst           (rst),
        .in            (in_drv),
        .fwd           (fwd_drv),
        .ex_mem        (ex_mem),
        .pc_src        (pc_src),
        .flush_if      (flush_if),
        .flush_id      (flush_id),
        .branch_target (branch_target)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > cycle_limit) begin
            $display("timeout: run still busy after %0d cycles", cycle_limit);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            fail_count++;
        end else begin
            pass_count++;
        end
    endtask

    // ==================================================
    // stimulus table
    // ==================================================
    task automatic add_row(
        input alu_op_e         alu_op,
        input src_b_e          src_b,
        input br_kind_e        br_kind,
        input logic [XLEN-1:0] pc,
        input logic [XLEN-1:0] imm,
        input logic [XLEN-1:0] rs1,
        input logic [XLEN-1:0] rs2,
        input logic [XLEN-1:0] csr,
        input logic [XLEN-1:0] e_alu,
        input logic [XLEN-1:0] e_csr,
        input logic            e_taken,
        input logic [XLEN-1:0] e_target
    );
        ex_in_t r;
        r = '0;
        r.op_valid        = 1'b1;
        r.ctrl.alu_op     = alu_op;
        r.ctrl.src_a      = src_a_rs1;
        r.ctrl.src_b      = src_b;
        r.ctrl.br_kind    = br_kind;
        r.ctrl.csr_op     = csr_op_none;
        r.ctrl.write_gpr  = 1'b1;
        r.ctrl.write_csr  = n_rows[0] & n_rows[2];
        r.ctrl.mem_to_reg = n_rows[0];
        r.ctrl.write_mem  = n_rows[0] & n_rows[1];
        r.ctrl.mem_size   = mem_size_e'(3'(n_rows % 5));
        r.ctrl.halt       = n_rows[0] & n_rows[1] & n_rows[2];
        // index fields vary per row to show pass-through
        r.rd       = 5'(n_rows);
        r.rs1      = 5'(n_rows + 1);
        r.rs2      = 5'(n_rows + 2);
        r.csr_rd   = 2'(n_rows);
        r.csr_rs   = 2'(n_rows + 1);
        r.pc       = pc;
        r.imm      = imm;
        r.rs1_data = rs1;
        r.rs2_data = rs2;
        r.csr_data = csr;
        tbl_in[n_rows]     = r;
        tbl_fwd[n_rows]    = '0;
        exp_alu[n_rows]    = e_alu;
        exp_csr[n_rows]    = e_csr;
        exp_taken[n_rows]  = e_taken;
        exp_target[n_rows] = e_target;
        n_rows++;
    endtask

    // modifiers for the last added row
    task automatic use_pc_as_a();
        tbl_in[n_rows-1].ctrl.src_a = src_a_pc;
    endtask

    task automatic set_csr_op(input csr_op_e op);
        tbl_in[n_rows-1].ctrl.csr_op    = op;
        tbl_in[n_rows-1].ctrl.write_csr = 1'b1;
    endtask

    task automatic clear_valid();
        tbl_in[n_rows-1].op_valid = 1'b0;
    endtask

    task automatic add_fwd(input logic rs1_hz, input logic rs2_hz, input logic csr_hz,
                           input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                           input logic [XLEN-1:0] csr);
        tbl_fwd[n_rows-1] = '{rs1, rs2, csr, rs1_hz, rs2_hz, csr_hz};
    endtask

    task automatic build_table();
        // pc, imm, rs1, rs2, csr, then alu_out, csr_out, taken, target
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 5, 7, 0, 'hc, 0, 0, 0);
        add_row(alu_sub, src_b_rs2, br_none, 'h100, 0, 5, 7, 0, 'hfffffffe, 0, 0, 0);
        add_row(alu_slt, src_b_rs2, br_none, 'h100, 0, 'hffffffff, 1, 0, 1, 0, 0, 0);
        add_row(alu_sltu, src_b_rs2, br_none, 'h100, 0, 'hffffffff, 1, 0, 0, 0, 0, 0);
        add_row(alu_or, src_b_imm, br_none, 'h100, 'hf, 'hf0, 0, 0, 'hff, 0, 0, 0);
        add_row(alu_and, src_b_rs2, br_none, 'h100, 0, 'hf0f0, 'hff00, 0, 'hf000, 0, 0, 0);
        add_row(alu_xor, src_b_rs2, br_none, 'h100, 0, 'haaaa, 'hffff, 0, 'h5555, 0, 0, 0);
        add_row(alu_sll, src_b_imm, br_none, 'h100, 'h24, 1, 0, 0, 'h10, 0, 0, 0);
        add_row(alu_srl, src_b_rs2, br_none, 'h100, 0, 'h80000000, 4, 0, 'h08000000, 0, 0, 0);
        add_row(alu_sra, src_b_rs2, br_none, 'h100, 0, 'h80000000, 4, 0, 'hf8000000, 0, 0, 0);
        add_row(alu_pass_b, src_b_imm, br_none, 'h100, 'h12345000, 0, 0, 0, 'h12345000, 0, 0, 0);
        add_row(alu_add, src_b_four, br_none, 'h200, 0, 0, 0, 0, 'h204, 0, 0, 0);
        use_pc_as_a();
        add_row(alu_add, src_b_imm, br_none, 'h200, 'h10, 0, 0, 0, 'h210, 0, 0, 0);
        use_pc_as_a();
        add_row(alu_add, src_b_csr, br_none, 'h100, 0, 3, 0, 'h40, 'h43, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 1, 2, 0, 'h300, 0, 0, 0);
        add_fwd(1, 1, 0, 'h100, 'h200, 0);
        // csr rw, rs and ecall
        add_row(alu_pass_b, src_b_csr, br_none, 'h100, 0, 'h77, 0, 'h55, 'h55, 'h77, 0, 0);
        set_csr_op(csr_op_rw);
        add_row(alu_pass_b, src_b_csr, br_none, 'h100, 0, 3, 0, 1, 'h10, 'h13, 0, 0);
        set_csr_op(csr_op_rs);
        add_fwd(0, 0, 1, 0, 0, 'h10);
        add_row(alu_pass_b, src_b_imm, br_none, 'h300, 0, 0, 0, 0, 0, 'h300, 0, 0);
        set_csr_op(csr_op_ecall);
        // conditional branches, each taken one followed by a shadow
        add_row(alu_add, src_b_rs2, br_beq, 'h400, 'h20, 5, 6, 0, 'hb, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_bne, 'h420, 'h40, 4, 4, 0, 8, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_beq, 'h400, 'h20, 9, 9, 0, 'h12, 0, 1, 'h420);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 6, 1, 0, 7, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_bne, 'h420, 'h40, 1, 2, 0, 3, 0, 1, 'h460);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 8, 8, 0, 'h10, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_bge, 'h500, 'h40, 'hffffffff, 1, 0, 0, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_blt, 'h500, 'hfffffff0, 'hffffffff, 1, 0, 0, 0, 1, 'h4f0);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 2, 3, 0, 5, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_bge, 'h600, 8, 5, 5, 0, 'ha, 0, 1, 'h608);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 0, 0, 0, 0, 0, 0, 0);
        // bubble with a jump must not redirect
        add_row(alu_add, src_b_four, br_jmp_pc, 'h700, 'h40, 0, 0, 0, 'h704, 0, 1, 'h740);
        use_pc_as_a();
        clear_valid();
        add_row(alu_add, src_b_four, br_jmp_pc, 'h700, 'h40, 0, 0, 0, 'h704, 0, 1, 'h740);
        use_pc_as_a();
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 1, 1, 0, 2, 0, 0, 0);
        add_row(alu_add, src_b_four, br_jmp_rs1, 'h800, 'h10, 'h999, 0, 0, 'h804, 0, 1, 'h1010);
        use_pc_as_a();
        add_fwd(1, 0, 0, 'h1001, 0, 0);
        add_row(alu_sub, src_b_rs2, br_none, 'h100, 0, 9, 4, 0, 5, 0, 0, 0);
        add_row(alu_pass_b, src_b_csr, br_jmp_csr, 'h900, 4, 0, 0, 'h10, 'h2000, 0, 1, 'h2004);
        add_fwd(0, 0, 1, 0, 0, 'h2000);
        add_row(alu_xor, src_b_rs2, br_none, 'h100, 0, 3, 1, 0, 2, 0, 0, 0);
        add_row(alu_add, src_b_rs2, br_blt, 'ha00, 'h100, 1, 0, 0, 6, 0, 1, 'hb00);
        add_fwd(0, 1, 0, 0, 5, 0);
        add_row(alu_add, src_b_rs2, br_none, 'h100, 0, 0, 0, 0, 0, 0, 0, 0);
        clear_valid();
    endtask

    task automatic check_row(input int i);
        string p;
        logic  exp_valid;
        logic  exp_redirect;
        p            = $sformatf("row %0d ", i);
        exp_valid    = tbl_in[i].op_valid & ~shadow_exp;
        exp_redirect = exp_taken[i] & exp_valid;
        check_value({p, "alu_out"}, ex_mem.alu_out, exp_alu[i]);
        check_value({p, "csr_out"}, ex_mem.csr_out, exp_csr[i]);
        check_value({p, "op_valid"}, 32'(ex_mem.op_valid), 32'(exp_valid));
        check_value({p, "write_gpr"}, 32'(ex_mem.write_gpr),
                    32'(tbl_in[i].ctrl.write_gpr & exp_valid));
        check_value({p, "write_csr"}, 32'(ex_mem.write_csr),
                    32'(tbl_in[i].ctrl.write_csr & exp_valid));
        check_value({p, "write_mem"}, 32'(ex_mem.write_mem),
                    32'(tbl_in[i].ctrl.write_mem & exp_valid));
        check_value({p, "halt"}, 32'(ex_mem.halt), 32'(tbl_in[i].ctrl.halt & exp_valid));
        check_value({p, "pc_src"}, 32'(pc_src), 32'(exp_redirect));
        check_value({p, "flush_if"}, 32'(flush_if), 32'(exp_redirect));
        check_value({p, "flush_id"}, 32'(flush_id), 32'(exp_redirect));
        if (exp_redirect) begin
            check_value({p, "branch_target"}, branch_target, exp_target[i]);
        end
        if (exp_valid) begin
            check_value({p, "rd"}, 32'(ex_mem.rd), 32'(tbl_in[i].rd));
            check_value({p, "rs1"}, 32'(ex_mem.rs1), 32'(tbl_in[i].rs1));
            check_value({p, "rs2"}, 32'(ex_mem.rs2), 32'(tbl_in[i].rs2));
            check_value({p, "csr_rd"}, 32'(ex_mem.csr_rd), 32'(tbl_in[i].csr_rd));
            check_value({p, "csr_rs"}, 32'(ex_mem.csr_rs), 32'(tbl_in[i].csr_rs));
            check_value({p, "mem_to_reg"}, 32'(ex_mem.mem_to_reg),
                        32'(tbl_in[i].ctrl.mem_to_reg));
            check_value({p, "mem_size"}, 32'(ex_mem.mem_size), 32'(tbl_in[i].ctrl.mem_size));
        end
        // next row is a shadow
        shadow_exp = exp_redirect;
    endtask

    // ==================================================
    // reference model for the random phase
    // ==================================================
    function automatic logic [XLEN-1:0] ref_alu(input alu_op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
        logic [4:0] sh;
        sh = b[4:0];
        case (op)
            alu_add:    return a + b;
            alu_sub:    return a + ~b + 1;
            alu_slt:    return (a[31] != b[31]) ? XLEN'(a[31]) : XLEN'(a < b);
            alu_sltu:   return XLEN'(a < b);
            alu_or:     return a | b;
            alu_and:    return a & b;
            alu_xor:    return a ^ b;
            alu_sll:    return a << sh;
            alu_srl:    return a >> sh;
            // fill the vacated top bits with the sign
            alu_sra:    return (a >> sh) | ({XLEN{a[31]}} << (XLEN - int'(sh)));
            alu_pass_b: return b;
            default:    return '0;
        endcase
    endfunction

    task automatic run_random();
        ex_in_t          r;
        alu_op_e         op;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] exp;
        for (int k = 0; k < RAND_OPS; k++) begin
            op = alu_op_e'(4'($unsigned($random(seed)) % 11));
            a  = $random(seed);
            b  = $random(seed);
            r  = '0;
            r.op_valid       = 1'b1;
            r.ctrl.alu_op    = op;
            r.ctrl.write_gpr = 1'b1;
            r.rs1_data       = a;
            r.rs2_data       = b;
            exp     = ref_alu(op, a, b);
            in_drv  = r;
            fwd_drv = '0;
            @(negedge clk);
            check_value($sformatf("random %0d alu_out", k), ex_mem.alu_out, exp);
        end
    endtask

    // ==================================================
    // main sequence
    // ==================================================
    initial begin
        int fails_before;
        rst     = 1'b1;
        in_drv  = '0;
        fwd_drv = '0;
        seed    = 32'hd0f;
        build_table();
        cycle_limit = 5 + n_rows + RAND_OPS + 20;

        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("reset op_valid", 32'(ex_mem.op_valid), 0);
        check_value("reset write_gpr", 32'(ex_mem.write_gpr), 0);
        check_value("reset write_csr", 32'(ex_mem.write_csr), 0);
        check_value("reset write_mem", 32'(ex_mem.write_mem), 0);
        check_value("reset halt", 32'(ex_mem.halt), 0);
        check_value("reset pc_src", 32'(pc_src), 0);
        check_value("reset flush_if", 32'(flush_if), 0);
        check_value("reset flush_id", 32'(flush_id), 0);
        $display("test reset: %0d errors", fail_count);

        fails_before = fail_count;
        for (int i = 0; i < n_rows; i++) begin
            in_drv  = tbl_in[i];
            fwd_drv = tbl_fwd[i];
            @(negedge clk);
            check_row(i);
        end
        $display("test table: %0d rows, %0d errors", n_rows, fail_count - fails_before);

        fails_before = fail_count;
        run_random();
        in_drv = '0;
        $display("test random: %0d ops, %0d errors", RAND_OPS, fail_count - fails_before);

        $display("checks passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule
